/* design/touch_trail_pkg.sv */
package touch_trail_pkg;

    // raw touchpad sample as the serial controller delivers it
    typedef logic [8:0] touch_raw_t;

    // screen cell, raw coordinate divided by four
    typedef logic [6:0] cell_t;

    // age of a trail point in frames
    typedef logic [3:0] age_t;

    // pressure at or above this counts as a touch
    // same as requiring z >> 8 to be non-zero
    localparam touch_raw_t PRESS_THRESHOLD = 9'd256;

    // a point reaching this age drops out of the trail
    // also the brightness of a brand new point
    localparam age_t MAX_AGE = 4'd15;

    // max distance per axis, in cells, for a query to hit a point
    localparam cell_t HIT_RADIUS = 7'd2;

endpackage

/* design/touch_latch.sv */
module touch_latch
    import touch_trail_pkg::*;
(
    input  logic       tft_new_frame,
    input  logic       reset,
    input  touch_raw_t touch_x,
    input  touch_raw_t touch_y,
    input  touch_raw_t touch_z,
    output cell_t      cursor_x,
    output cell_t      cursor_y,
    output logic       cursor_valid,
    output logic       new_point
);

    logic accept;
    cell_t scaled_x;
    cell_t scaled_y;

    // enough pressure means a real touch this frame
    assign accept = (touch_z >= PRESS_THRESHOLD);

    // drop the two low bits to go from touchpad units to cells
    assign scaled_x = touch_x[8:2];
    assign scaled_y = touch_y[8:2];

    always_ff @(posedge tft_new_frame) begin
        if (reset) begin
            cursor_x     <= '0;
            cursor_y     <= '0;
            cursor_valid <= 1'b0;
            new_point    <= 1'b0;
        end else begin
            // one frame pulse per accepted touch
            new_point <= accept;
            if (accept) begin
                cursor_x     <= scaled_x;
                cursor_y     <= scaled_y;
                // sticky once the first touch arrives
                cursor_valid <= 1'b1;
            end
        end
    end

endmodule

/* design/trail_slot.sv */
module trail_slot
    import touch_trail_pkg::*;
(
    input  logic  tft_new_frame,
    input  logic  reset,
    input  logic  shift,
    input  cell_t in_x,
    input  cell_t in_y,
    input  logic  in_valid,
    input  age_t  in_age,
    output cell_t x,
    output cell_t y,
    output logic  valid,
    output age_t  age
);

    age_t in_next_age;
    age_t own_next_age;

    // entry moving in is one frame older than in the previous slot
    // slot 0 gets all ones here, which wraps to a fresh age of zero
    assign in_next_age  = in_age + age_t'(1);
    assign own_next_age = age + age_t'(1);

    // valid flag and age
    always_ff @(posedge tft_new_frame) begin
        if (reset) begin
            valid <= 1'b0;
            age   <= '0;
        end else if (shift) begin
            valid <= in_valid && (in_next_age != MAX_AGE);
            age   <= in_next_age;
        end else if (valid) begin
            // age in place until the point expires
            age <= own_next_age;
            if (own_next_age == MAX_AGE) begin
                valid <= 1'b0;
            end
        end
    end

    // coordinates only move along with a shift
    always_ff @(posedge tft_new_frame) begin
        if (shift) begin
            x <= in_x;
            y <= in_y;
        end
    end

endmodule

/* design/trail_hit_detect.sv */
module trail_hit_detect
    import touch_trail_pkg::*;
#(
    parameter int TRAIL_DEPTH = 4
) (
    input  cell_t                              query_x,
    input  cell_t                              query_y,
    input  logic [TRAIL_DEPTH*$bits(cell_t)-1:0] slot_x,
    input  logic [TRAIL_DEPTH*$bits(cell_t)-1:0] slot_y,
    input  logic [TRAIL_DEPTH-1:0]             slot_valid,
    input  logic [TRAIL_DEPTH*$bits(age_t)-1:0]  slot_age,
    output logic                               hit,
    output age_t                               hit_intensity
);

    localparam int CW = $bits(cell_t);
    localparam int AW = $bits(age_t);

    logic [TRAIL_DEPTH-1:0] near;

    // per slot distance test
    for (genvar i = 0; i < TRAIL_DEPTH; i++) begin : g_dist
        cell_t sx;
        cell_t sy;
        cell_t dx;
        cell_t dy;

        assign sx = slot_x[i*CW +: CW];
        assign sy = slot_y[i*CW +: CW];

        // absolute distance without going signed
        assign dx = (query_x > sx) ? (query_x - sx) : (sx - query_x);
        assign dy = (query_y > sy) ? (query_y - sy) : (sy - query_y);

        // square window, not a circle
        assign near[i] = slot_valid[i] && (dx <= HIT_RADIUS) && (dy <= HIT_RADIUS);
    end

    // walk from oldest to youngest so the lowest index wins
    always_comb begin
        hit           = 1'b0;
        hit_intensity = '0;
        for (int i = TRAIL_DEPTH - 1; i >= 0; i--) begin
            if (near[i]) begin
                hit           = 1'b1;
                hit_intensity = MAX_AGE - slot_age[i*AW +: AW];
            end
        end
    end

endmodule

/* design/touch_trail.sv */
module touch_trail
    import touch_trail_pkg::*;
#(
    parameter int TRAIL_DEPTH = 4
) (
    input  logic       tft_new_frame,
    input  logic       reset,
    input  touch_raw_t touch_x,
    input  touch_raw_t touch_y,
    input  touch_raw_t touch_z,
    input  cell_t      query_x,
    input  cell_t      query_y,
    output cell_t      cursor_x,
    output cell_t      cursor_y,
    output logic       cursor_valid,
    output logic       hit,
    output age_t       hit_intensity
);

    localparam int CW = $bits(cell_t);
    localparam int AW = $bits(age_t);

    logic new_point;

    // whole trail, slot 0 in the low bits
    logic [TRAIL_DEPTH*CW-1:0] slot_x;
    logic [TRAIL_DEPTH*CW-1:0] slot_y;
    logic [TRAIL_DEPTH-1:0]    slot_valid;
    logic [TRAIL_DEPTH*AW-1:0] slot_age;

    touch_latch i_touch_latch (
        .tft_new_frame (tft_new_frame),
        .reset         (reset),
        .touch_x       (touch_x),
        .touch_y       (touch_y),
        .touch_z       (touch_z),
        .cursor_x      (cursor_x),
        .cursor_y      (cursor_y),
        .cursor_valid  (cursor_valid),
        .new_point     (new_point)
    );

    for (genvar k = 0; k < TRAIL_DEPTH; k++) begin : g_slot
        if (k == 0) begin : g_head
            // head loads the fresh cursor point, age wraps to zero
            trail_slot i_trail_slot (
                .tft_new_frame (tft_new_frame),
                .reset         (reset),
                .shift         (new_point),
                .in_x          (cursor_x),
                .in_y          (cursor_y),
                .in_valid      (1'b1),
                .in_age        ('1),
                .x             (slot_x[0 +: CW]),
                .y             (slot_y[0 +: CW]),
                .valid         (slot_valid[0]),
                .age           (slot_age[0 +: AW])
            );
        end else begin : g_tail
            trail_slot i_trail_slot (
                .tft_new_frame (tft_new_frame),
                .reset         (reset),
                .shift         (new_point),
                .in_x          (slot_x[(k-1)*CW +: CW]),
                .in_y          (slot_y[(k-1)*CW +: CW]),
                .in_valid      (slot_valid[k-1]),
                .in_age        (slot_age[(k-1)*AW +: AW]),
                .x             (slot_x[k*CW +: CW]),
                .y             (slot_y[k*CW +: CW]),
                .valid         (slot_valid[k]),
                .age           (slot_age[k*AW +: AW])
            );
        end
    end

    trail_hit_detect #(
        .TRAIL_DEPTH (TRAIL_DEPTH)
    ) i_trail_hit_detect (
        .query_x       (query_x),
        .query_y       (query_y),
        .slot_x        (slot_x),
        .slot_y        (slot_y),
        .slot_valid    (slot_valid),
        .slot_age      (slot_age),
        .hit           (hit),
        .hit_intensity (hit_intensity)
    );

endmodule

/* testbench/touch_trail_sva.sv */
module touch_trail_sva
    import touch_trail_pkg::*;
(
    input logic       tft_new_frame,
    input logic       reset,
    input touch_raw_t touch_x,
    input touch_raw_t touch_y,
    input touch_raw_t touch_z,
    input cell_t      cursor_x,
    input cell_t      cursor_y,
    input logic       cursor_valid,
    input logic       hit,
    input age_t       hit_intensity
);

    cell_t touch_cell_x;
    cell_t touch_cell_y;

    // raw touchpad units to screen cells
    assign touch_cell_x = touch_x[8:2];
    assign touch_cell_y = touch_y[8:2];

    // a live point is never fully faded
    hit_has_intensity: assert property (
        @(posedge tft_new_frame) disable iff (reset)
        hit |-> (hit_intensity != '0)
    ) else $error("hit reported with zero intensity");

    // cursor_valid is sticky
    cursor_valid_sticky: assert property (
        @(posedge tft_new_frame) disable iff (reset)
        cursor_valid |=> cursor_valid
    ) else $error("cursor_valid dropped outside reset");

    // accepted touch lands on the cursor one frame later
    touch_to_cursor: assert property (
        @(posedge tft_new_frame) disable iff (reset)
        (touch_z >= PRESS_THRESHOLD) |=>
            (cursor_x == $past(touch_cell_x)) && (cursor_y == $past(touch_cell_y))
    ) else $error("accepted touch not shown on cursor");

endmodule

bind touch_trail touch_trail_sva i_touch_trail_sva (
    .tft_new_frame (tft_new_frame),
    .reset         (reset),
    .touch_x       (touch_x),
    .touch_y       (touch_y),
    .touch_z       (touch_z),
    .cursor_x      (cursor_x),
    .cursor_y      (cursor_y),
    .cursor_valid  (cursor_valid),
    .hit           (hit),
    .hit_intensity (hit_intensity)
);

/* testbench/touch_trail_tb.sv */
module touch_trail_tb
    import touch_trail_pkg::*;
();

    localparam int TRAIL_DEPTH    = 4;
    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 2;
    localparam int DRIVE_DELAY    = 2;
    // checks land one time unit before the next rising edge
    localparam int SAMPLE_DELAY   = CLK_PERIOD - DRIVE_DELAY - 1;
    localparam int NUM_ROWS       = 34;
    localparam int TIMEOUT_CYCLES = NUM_ROWS + 20;

    logic       tft_new_frame;
    logic       reset;
    touch_raw_t touch_x;
    touch_raw_t touch_y;
    touch_raw_t touch_z;
    cell_t      query_x;
    cell_t      query_y;
    cell_t      cursor_x;
    cell_t      cursor_y;
    logic       cursor_valid;
    logic       hit;
    age_t       hit_intensity;

    // one table row per frame
    string      row_name         [NUM_ROWS];
    touch_raw_t row_touch_x      [NUM_ROWS];
    touch_raw_t row_touch_y      [NUM_ROWS];
    touch_raw_t row_touch_z      [NUM_ROWS];
    cell_t      row_query_x      [NUM_ROWS];
    cell_t      row_query_y      [NUM_ROWS];
    cell_t      row_cursor_x     [NUM_ROWS];
    cell_t      row_cursor_y     [NUM_ROWS];
    logic       row_cursor_valid [NUM_ROWS];
    logic       row_hit          [NUM_ROWS];
    age_t       row_intensity    [NUM_ROWS];

    int row_count   = 0;
    int cycle_count = 0;

    touch_trail #(
        .TRAIL_DEPTH (TRAIL_DEPTH)
    ) i_touch_trail (
        .tft_new_frame (tft_new_frame),
        .reset         (reset),
        .touch_x       (touch_x),
        .touch_y       (touch_y),
        .touch_z       (touch_z),
        .query_x       (query_x),
        .query_y       (query_y),
        .cursor_x      (cursor_x),
        .cursor_y      (cursor_y),
        .cursor_valid  (cursor_valid),
        .hit           (hit),
        .hit_intensity (hit_intensity)
    );

    initial begin
        tft_new_frame = 1'b0;
        forever #(CLK_PERIOD / 2) tft_new_frame = ~tft_new_frame;
    end

    task automatic add_row(
        input string name,
        input int    tx,
        input int    ty,
        input int    tz,
        input int    qx,
        input int    qy,
        input int    cx,
        input int    cy,
        input int    cv,
        input int    h,
        input int    hi
    );
        row_name[row_count]         = name;
        row_touch_x[row_count]      = touch_raw_t'(tx);
        row_touch_y[row_count]      = touch_raw_t'(ty);
        row_touch_z[row_count]      = touch_raw_t'(tz);
        row_query_x[row_count]      = cell_t'(qx);
        row_query_y[row_count]      = cell_t'(qy);
        row_cursor_x[row_count]     = cell_t'(cx);
        row_cursor_y[row_count]     = cell_t'(cy);
        row_cursor_valid[row_count] = (cv != 0);
        row_hit[row_count]          = (h != 0);
        row_intensity[row_count]    = age_t'(hi);
        row_count++;
    endtask

    // a touch driven in row n shows on the cursor in row n+1
    // and enters the trail with intensity 15 in row n+2
    task automatic build_table();
        // name                     tx   ty   tz   qx   qy  cx  cy  cv hit int
        add_row("after_reset",        0,   0,   0,  50,  30,  0,  0, 0, 0,  0);
        add_row("press_255",        203, 121, 255,  50,  30,  0,  0, 0, 0,  0);
        add_row("press_256",        203, 121, 256,  50,  30,  0,  0, 0, 0,  0);
        add_row("cursor_set",       400, 400, 100,  50,  30, 50, 30, 1, 0,  0);
        add_row("first_hit",          0,   0,   0,  50,  30, 50, 30, 1, 1, 15);
        add_row("fade_one",           0,   0,   0,  50,  30, 50, 30, 1, 1, 14);
        add_row("corner_plus_two",    0,   0,   0,  52,  32, 50, 30, 1, 1, 13);
        add_row("corner_minus_two",   0,   0,   0,  48,  28, 50, 30, 1, 1, 12);
        add_row("x_three_away",       0,   0,   0,  53,  30, 50, 30, 1, 0,  0);
        add_row("y_three_away",       0,   0,   0,  50,  27, 50, 30, 1, 0,  0);
        add_row("light_press",      300, 300, 255,  51,  31, 50, 30, 1, 1,  9);
        add_row("hold_after_light",   0,   0,   0,  50,  30, 50, 30, 1, 1,  8);
        add_row("fade_7",             0,   0,   0,  50,  30, 50, 30, 1, 1,  7);
        add_row("fade_6",             0,   0,   0,  50,  30, 50, 30, 1, 1,  6);
        add_row("fade_5",             0,   0,   0,  50,  30, 50, 30, 1, 1,  5);
        add_row("fade_4",             0,   0,   0,  50,  30, 50, 30, 1, 1,  4);
        add_row("fade_3",             0,   0,   0,  50,  30, 50, 30, 1, 1,  3);
        add_row("fade_2",             0,   0,   0,  50,  30, 50, 30, 1, 1,  2);
        add_row("last_lit_frame",     0,   0,   0,  50,  30, 50, 30, 1, 1,  1);
        add_row("expired",            0,   0,   0,  50,  30, 50, 30, 1, 0,  0);
        // burst of points for overlap and push-out
        add_row("touch_a",          400,  80, 300,  50,  30, 50, 30, 1, 0,  0);
        add_row("touch_b",          408,  84, 511, 101,  20,100, 20, 1, 0,  0);
        add_row("a_queryable",        0,   0,   0, 101,  20,102, 21, 1, 1, 15);
        add_row("newest_wins",        0,   0,   0, 101,  20,102, 21, 1, 1, 15);
        add_row("newest_fades",       0,   0,   0, 101,  20,102, 21, 1, 1, 14);
        add_row("older_alone",        0,   0,   0,  98,  20,102, 21, 1, 1, 12);
        add_row("touch_c",           40,  40, 256,  98,  20,102, 21, 1, 1, 11);
        add_row("touch_d",           80,  40, 256,  98,  20, 10, 10, 1, 1, 10);
        add_row("touch_e",          120,  40, 256,  98,  19, 20, 10, 1, 1,  9);
        add_row("a_in_last_slot",     0,   0,   0,  98,  19, 30, 10, 1, 1,  8);
        add_row("a_pushed_out",       0,   0,   0,  98,  19, 30, 10, 1, 0,  0);
        add_row("b_in_last_slot",     0,   0,   0, 102,  21, 30, 10, 1, 1,  7);
        add_row("c_in_third_slot",    0,   0,   0,  10,  10, 30, 10, 1, 1, 11);
        add_row("e_in_first_slot",    0,   0,   0,  30,  10, 30, 10, 1, 1, 12);
    endtask

    task automatic report_mismatch(
        input string test,
        input string signal,
        input int    expected,
        input int    actual
    );
        $display("[ERROR] %s: %s expected %0d actual %0d", test, signal, expected, actual);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic apply_row(input int i);
        touch_x = row_touch_x[i];
        touch_y = row_touch_y[i];
        touch_z = row_touch_z[i];
        query_x = row_query_x[i];
        query_y = row_query_y[i];
    endtask

    task automatic check_outputs(input int i);
        assert (cursor_valid == row_cursor_valid[i])
            else report_mismatch(row_name[i], "cursor_valid",
                                 int'(row_cursor_valid[i]), int'(cursor_valid));
        assert (cursor_x == row_cursor_x[i])
            else report_mismatch(row_name[i], "cursor_x",
                                 int'(row_cursor_x[i]), int'(cursor_x));
        assert (cursor_y == row_cursor_y[i])
            else report_mismatch(row_name[i], "cursor_y",
                                 int'(row_cursor_y[i]), int'(cursor_y));
        assert (hit == row_hit[i])
            else report_mismatch(row_name[i], "hit",
                                 int'(row_hit[i]), int'(hit));
        assert (hit_intensity == row_intensity[i])
            else report_mismatch(row_name[i], "hit_intensity",
                                 int'(row_intensity[i]), int'(hit_intensity));
    endtask

    initial begin
        reset   = 1'b1;
        touch_x = '0;
        touch_y = '0;
        touch_z = '0;
        query_x = '0;
        query_y = '0;

        build_table();
        if (row_count != NUM_ROWS) begin
            $display("stimulus table has %0d rows instead of %0d", row_count, NUM_ROWS);
            $display("SOME TESTS FAILED");
            $fatal(1, "bad table size");
        end

        repeat (RESET_CYCLES) @(posedge tft_new_frame);
        #(DRIVE_DELAY);
        reset = 1'b0;

        for (int i = 0; i < NUM_ROWS; i++) begin
            if (i > 0) begin
                @(posedge tft_new_frame);
                #(DRIVE_DELAY);
            end
            apply_row(i);
            #(SAMPLE_DELAY);
            check_outputs(i);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

    // guard against a stalled run
    always @(posedge tft_new_frame) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d frames", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

endmodule

/* compile.f */
design/touch_trail_pkg.sv
design/touch_latch.sv
design/trail_slot.sv
design/trail_hit_detect.sv
design/touch_trail.sv
testbench/touch_trail_sva.sv
testbench/touch_trail_tb.sv

/* Makefile */
SOURCES := $(shell cat compile.f)

.PHONY: all run clean

all: run

obj_dir/Vtouch_trail_tb: compile.f $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module touch_trail_tb -f compile.f

run: obj_dir/Vtouch_trail_tb
	@out="$$(./obj_dir/Vtouch_trail_tb 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
